/* bench/graph_patterns.hex */
// Per test: header {00, prog_len, dma count, base}, 4 program words, 2 DMA words {dir, sram, page, len}
// then 6 initial data words and 6 expected data words, base byte in the top byte
// 1: RELU in place over 16 bytes, neighbours untouched
00010010 10141410 00000000 00000000 00000000
00000000 00000000
11223344 80FF007F 01FE40C0 8105F010 7E02FB3C 55667788
11223344 0000007F 01004000 00050010 7E02003C 55667788
// 2: NEG into src+1, then ABS into src-2
00020040 11404106 124C4A06 00000000 00000000
00000000 00000000
8001FF7F 009C33AA BBCC1234 80F60A81 00FF0102 03040506
8080FF01 810064AA BBCC800A 0A7F0001 00FF0102 03040506
// 3: single DMA, data unchanged
00010170 28705A20 00000000 00000000 00000000
01705A20 00000000
01234567 89ABCDEF FEDCBA98 76543210 0F1E2D3C 4B5A6978
01234567 89ABCDEF FEDCBA98 76543210 0F1E2D3C 4B5A6978
// 4: DMA, NEG, DMA on one credit
000302A0 20A01108 11A0B004 28B02204 00000000
00A01108 01B02204
05FB807F 11121314 15161718 191A1B1C C0C0C0C0 21222324
05FB807F 11121314 15161718 191A1B1C FB058081 21222324
// 5: END after the first word, later words must not run
000400C8 10C8C804 F0000000 11D0D004 12D8D804
00000000 00000000
817FF010 01020304 80FF0590 05060708 F1F2F3F4 090A0B0C
007F0010 01020304 80FF0590 05060708 F1F2F3F4 090A0B0C
// 6: element-wise word with len 0
000100E0 11E0E000 00000000 00000000 00000000
00000000 00000000
80818283 84858687 88898A8B 8C8D8E8F 90919293 94959697
80818283 84858687 88898A8B 8C8D8E8F 90919293 94959697

/* src.f */
hdl/npu_pkg.sv
hdl/graph_isa_pkg.sv
hdl/graph_intf.sv
hdl/graph_sequencer.sv
hdl/ew_engine.sv
hdl/dma_shim.sv
hdl/data_sram.sv
hdl/onnx_graph_top.sv
bench/graph_properties.sv
bench/graph_checker.sv
bench/tb_graph.sv

/* bench/tb_graph.sv */
module tb_graph;

    localparam int NUM_TESTS      = 6;
    localparam int REC_WORDS      = 19;
    localparam int PROG_SLOTS     = 4;
    localparam int DATA_BYTES     = 24;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (PROG_SLOTS * 280) + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic [7:0]  prog_len;
    logic        prog_wr_en;
    logic [5:0]  prog_wr_addr;
    logic [31:0] prog_wr_data;
    logic        sram_wr_en;
    logic [7:0]  sram_wr_addr;
    logic [7:0]  sram_wr_data;
    logic        sram_rd_en;
    logic [7:0]  sram_rd_addr;
    logic [7:0]  sram_rd_data;
    logic        dma_done_pulse;
    logic        dma_cmd_captured;
    logic [7:0]  dma_sram_addr;
    logic [7:0]  dma_ddr_page;
    logic [7:0]  dma_length;
    logic        dma_direction;
    logic        graph_done;
    logic        graph_busy;
    logic [7:0]  graph_pc;
    int          error_count;
    int          cycle_count = 0;
    integer      seed = 32'hbb3c_5f66;
    logic [31:0] patterns [0:NUM_TESTS*REC_WORDS-1];

    onnx_graph_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .prog_len         (prog_len),
        .graph_done       (graph_done),
        .graph_busy       (graph_busy),
        .graph_pc         (graph_pc),
        .prog_wr_en       (prog_wr_en),
        .prog_wr_addr     (prog_wr_addr),
        .prog_wr_data     (prog_wr_data),
        .sram_wr_en       (sram_wr_en),
        .sram_wr_addr     (sram_wr_addr),
        .sram_wr_data     (sram_wr_data),
        .sram_rd_en       (sram_rd_en),
        .sram_rd_addr     (sram_rd_addr),
        .sram_rd_data     (sram_rd_data),
        .dma_cmd_captured (dma_cmd_captured),
        .dma_sram_addr    (dma_sram_addr),
        .dma_ddr_page     (dma_ddr_page),
        .dma_length       (dma_length),
        .dma_direction    (dma_direction),
        .dma_done_pulse   (dma_done_pulse)
    );

    graph_checker u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .sram_rd_en       (sram_rd_en),
        .sram_rd_addr     (sram_rd_addr),
        .sram_rd_data     (sram_rd_data),
        .dma_cmd_captured (dma_cmd_captured),
        .dma_sram_addr    (dma_sram_addr),
        .dma_ddr_page     (dma_ddr_page),
        .dma_length       (dma_length),
        .dma_direction    (dma_direction),
        .dma_done_pulse   (dma_done_pulse),
        .graph_done       (graph_done),
        .graph_busy       (graph_busy),
        .graph_pc         (graph_pc),
        .error_count      (error_count)
    );

    always #10 clk = ~clk;

    // ======================================================================
    // Run limit and DMA responder
    // ======================================================================
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Each captured command is answered after 1 to 20 cycles
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            if (dma_cmd_captured) begin
                delay = 1 + ($unsigned($random(seed)) % 20);
                repeat (delay - 1) @(posedge clk);
                #1 dma_done_pulse = 1'b1;
                @(posedge clk);
                #1 dma_done_pulse = 1'b0;
            end
        end
    end

    // ======================================================================
    // Drive tasks, each entered 1 unit after a rising edge
    // ======================================================================
    function automatic logic [7:0] pick_byte(input logic [31:0] w, input int lane);
        return w[31 - 8*lane -: 8];
    endfunction

    // Fetch address at the end of a run, the END word or one past the last word
    function automatic logic [7:0] final_pc(input int rec, input logic [7:0] len);
        int i;
        for (i = 0; i < len && i < PROG_SLOTS; i++) begin
            if (patterns[rec + 1 + i][31:28] == 4'hf) begin
                return 8'(i);
            end
        end
        return len;
    endfunction

    task automatic write_prog(input logic [5:0] addr, input logic [31:0] word);
        prog_wr_en   = 1'b1;
        prog_wr_addr = addr;
        prog_wr_data = word;
        @(posedge clk);
        #1;
        prog_wr_en = 1'b0;
    endtask

    task automatic write_byte(input logic [7:0] addr, input logic [7:0] value);
        sram_wr_en   = 1'b1;
        sram_wr_addr = addr;
        sram_wr_data = value;
        @(posedge clk);
        #1;
        sram_wr_en = 1'b0;
    endtask

    task automatic read_byte(input logic [7:0] addr);
        sram_rd_en   = 1'b1;
        sram_rd_addr = addr;
        @(posedge clk);
        #1;
        sram_rd_en = 1'b0;
    endtask

    task automatic launch_graph(input logic [7:0] len);
        prog_len = len;
        start    = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!graph_done);
    endtask

    // Record: header, program words, DMA fields, initial bytes, expected bytes
    task automatic run_test(input int t);
        int          rec;
        int          i;
        logic [31:0] header;
        logic [7:0]  base;
        logic [7:0]  n_dma;
        rec    = t * REC_WORDS;
        header = patterns[rec];
        base   = header[7:0];
        n_dma  = header[15:8];
        for (i = 0; i < PROG_SLOTS; i++) begin
            write_prog(6'(i), patterns[rec + 1 + i]);
        end
        for (i = 0; i < DATA_BYTES; i++) begin
            write_byte(base + 8'(i), pick_byte(patterns[rec + 7 + i / 4], i % 4));
        end
        for (i = 0; i < n_dma; i++) begin
            u_checker.expect_dma(patterns[rec + 5 + i]);
        end
        u_checker.expect_pc(final_pc(rec, header[23:16]));
        launch_graph(header[23:16]);
        for (i = 0; i < DATA_BYTES; i++) begin
            u_checker.expect_byte(base + 8'(i), pick_byte(patterns[rec + 13 + i / 4], i % 4));
            read_byte(base + 8'(i));
        end
        // Let the last read data reach the checker
        repeat (2) @(posedge clk);
        #1;
        u_checker.close_test(t);
    endtask

    initial begin
        int t;
        rst_n          = 1'b0;
        start          = 1'b0;
        prog_len       = '0;
        prog_wr_en     = 1'b0;
        prog_wr_addr   = '0;
        prog_wr_data   = '0;
        sram_wr_en     = 1'b0;
        sram_wr_addr   = '0;
        sram_wr_data   = '0;
        sram_rd_en     = 1'b0;
        sram_rd_addr   = '0;
        dma_done_pulse = 1'b0;
        $readmemh("bench/graph_patterns.hex", patterns);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        u_checker.print_summary();
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* bench/graph_checker.sv */
// Watches the DUT ports and compares against queued expected values
module graph_checker (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sram_rd_en,
    input  logic [7:0] sram_rd_addr,
    input  logic [7:0] sram_rd_data,
    input  logic       dma_cmd_captured,
    input  logic [7:0] dma_sram_addr,
    input  logic [7:0] dma_ddr_page,
    input  logic [7:0] dma_length,
    input  logic       dma_direction,
    input  logic       dma_done_pulse,
    input  logic       graph_done,
    input  logic       graph_busy,
    input  logic [7:0] graph_pc,
    output int         error_count
);

    logic [7:0]  exp_addr [$];
    logic [7:0]  exp_data [$];
    logic [31:0] exp_dma [$];
    logic [7:0]  exp_pc [$];
    logic        rd_pend;
    logic [7:0]  rd_addr_q;
    logic        dma_open;
    logic [7:0]  want_addr;
    logic [7:0]  want_data;
    logic [31:0] want_dma;
    logic [31:0] seen_dma;
    logic [7:0]  want_pc;
    int          test_errors;
    int          check_count;
    int          tests_passed;
    int          tests_failed;

    initial begin
        error_count  = 0;
        test_errors  = 0;
        check_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    // ======================================================================
    // Reporting
    // ======================================================================
    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic expect_byte(input logic [7:0] addr, input logic [7:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    task automatic expect_dma(input logic [31:0] fields);
        exp_dma.push_back(fields);
    endtask

    task automatic expect_pc(input logic [7:0] value);
        exp_pc.push_back(value);
    endtask

    task automatic close_test(input int t);
        if (exp_dma.size() != 0) begin
            report_problem($sformatf("%0d expected DMA commands never appeared", exp_dma.size()));
            exp_dma.delete();
        end
        if (exp_data.size() != 0) begin
            report_problem($sformatf("%0d expected SRAM reads never returned", exp_data.size()));
            exp_addr.delete();
            exp_data.delete();
        end
        if (exp_pc.size() != 0) begin
            report_problem("graph_done never pulsed for this run");
            exp_pc.delete();
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d finished: ok", t + 1);
        end else begin
            tests_failed++;
            $display("Test %0d finished: %0d errors", t + 1, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic print_summary();
        $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 check_count, error_count);
    endtask

    // ======================================================================
    // Port monitor
    // ======================================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend  <= 1'b0;
            dma_open <= 1'b0;
        end else begin
            rd_pend   <= sram_rd_en;
            rd_addr_q <= sram_rd_addr;

            // Read data is valid one cycle after the enable
            if (rd_pend) begin
                if (exp_data.size() == 0) begin
                    report_problem($sformatf("SRAM read of %02h had no expected value", rd_addr_q));
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    check_count++;
                    if (rd_addr_q !== want_addr || sram_rd_data !== want_data) begin
                        report_mismatch($sformatf("sram[%02h] read %02h, expected %02h at %02h",
                                        rd_addr_q, sram_rd_data, want_data, want_addr));
                    end
                end
            end

            if (dma_cmd_captured) begin
                check_count++;
                if (dma_open) begin
                    report_problem("DMA command captured before the previous done pulse");
                end
                seen_dma = {7'd0, dma_direction, dma_sram_addr, dma_ddr_page, dma_length};
                if (exp_dma.size() == 0) begin
                    report_problem("DMA command captured that the program did not hold");
                end else begin
                    want_dma = exp_dma.pop_front();
                    if (seen_dma !== want_dma) begin
                        report_mismatch($sformatf("DMA fields %08h, expected %08h",
                                        seen_dma, want_dma));
                    end
                end
            end

            if (dma_cmd_captured) begin
                dma_open <= 1'b1;
            end else if (dma_done_pulse) begin
                dma_open <= 1'b0;
            end

            if (graph_done && graph_busy) begin
                report_problem("graph_busy was still high while graph_done pulsed");
            end

            // Program counter where the run stopped
            if (graph_done) begin
                check_count++;
                if (exp_pc.size() == 0) begin
                    report_problem("graph_done pulsed with no run pending");
                end else begin
                    want_pc = exp_pc.pop_front();
                    if (graph_pc !== want_pc) begin
                        report_mismatch($sformatf("graph_pc %02h at graph_done, expected %02h",
                                        graph_pc, want_pc));
                    end
                end
            end
        end
    end

endmodule

/* bench/graph_properties.sv */
// Protocol checks on the sequencer and the DMA shim
module graph_properties (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] credit,
    input  logic       graph_done,
    input  logic       graph_busy,
    input  logic       active,
    input  logic       dma_issue
);

    // Only one DMA credit exists in the design
    a_credit_max : assert property (
        @(posedge clk) disable iff (!rst_n) credit <= 2'd1
    ) else $error("DMA credit count went above one");

    // A new command only arrives when the shim has no command in flight
    a_issue_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n) dma_issue |-> !active
    ) else $error("DMA command issued while the shim was still active");

    a_done_not_busy : assert property (
        @(posedge clk) disable iff (!rst_n) !(graph_done && graph_busy)
    ) else $error("graph_done and graph_busy high in the same cycle");

endmodule

bind graph_sequencer graph_properties u_seq_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .credit     (credit),
    .graph_done (graph_done),
    .graph_busy (graph_busy),
    .active     (1'b0),
    .dma_issue  (1'b0)
);

bind dma_shim graph_properties u_shim_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .credit     (2'd1),
    .graph_done (1'b0),
    .graph_busy (1'b0),
    .active     (active),
    .dma_issue  (dma_issue)
);

/* hdl/onnx_graph_top.sv */
module onnx_graph_top
    import npu_pkg::*;
    import graph_isa_pkg::*;
#(
    parameter int DATA_AW = npu_pkg::DATA_AW,
    parameter int PROG_AW = npu_pkg::PROG_AW
)(
    input  logic               clk,
    input  logic               rst_n,
    // Control
    input  logic               start,
    input  logic [7:0]         prog_len,
    output logic               graph_done,
    output logic               graph_busy,
    output logic [7:0]         graph_pc,
    // Program load
    input  logic               prog_wr_en,
    input  logic [PROG_AW-1:0] prog_wr_addr,
    input  logic [31:0]        prog_wr_data,
    // Data SRAM access from the testbench
    input  logic               sram_wr_en,
    input  logic [DATA_AW-1:0] sram_wr_addr,
    input  data_t              sram_wr_data,
    input  logic               sram_rd_en,
    input  logic [DATA_AW-1:0] sram_rd_addr,
    output data_t              sram_rd_data,
    // DMA command out, done pulse back
    output logic               dma_cmd_captured,
    output logic [7:0]         dma_sram_addr,
    output logic [7:0]         dma_ddr_page,
    output logic [7:0]         dma_length,
    output logic               dma_direction,
    input  logic               dma_done_pulse
);

    logic       dma_issue;
    dma_instr_t dma_instr;
    logic       credit_return;

    ew_cmd_if                           u_ew_if ();
    sram_port_if #(.DATA_AW(DATA_AW))   u_sram_if ();

    graph_sequencer #(.PROG_AW(PROG_AW)) u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .prog_len      (prog_len),
        .prog_wr_en    (prog_wr_en),
        .prog_wr_addr  (prog_wr_addr),
        .prog_wr_data  (prog_wr_data),
        .credit_return (credit_return),
        .ew            (u_ew_if.seq),
        .dma_issue     (dma_issue),
        .dma_instr     (dma_instr),
        .graph_done    (graph_done),
        .graph_busy    (graph_busy),
        .graph_pc      (graph_pc)
    );

    ew_engine #(.DATA_AW(DATA_AW)) u_ew_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (u_ew_if.eng),
        .mem   (u_sram_if.master)
    );

    dma_shim u_dma_shim (
        .clk              (clk),
        .rst_n            (rst_n),
        .dma_issue        (dma_issue),
        .dma_instr        (dma_instr),
        .dma_done_pulse   (dma_done_pulse),
        .credit_return    (credit_return),
        .dma_cmd_captured (dma_cmd_captured),
        .dma_sram_addr    (dma_sram_addr),
        .dma_ddr_page     (dma_ddr_page),
        .dma_length       (dma_length),
        .dma_direction    (dma_direction)
    );

    data_sram #(.DATA_AW(DATA_AW)) u_data_sram (
        .clk        (clk),
        .eng        (u_sram_if.slave),
        .tb_rd_en   (sram_rd_en),
        .tb_rd_addr (sram_rd_addr),
        .tb_rd_data (sram_rd_data),
        .tb_wr_en   (sram_wr_en),
        .tb_wr_addr (sram_wr_addr),
        .tb_wr_data (sram_wr_data)
    );

endmodule

/* hdl/data_sram.sv */
module data_sram
    import npu_pkg::*;
#(
    parameter int DATA_AW = npu_pkg::DATA_AW
)(
    input  logic               clk,
    sram_port_if.slave         eng,
    input  logic               tb_rd_en,
    input  logic [DATA_AW-1:0] tb_rd_addr,
    output data_t              tb_rd_data,
    input  logic               tb_wr_en,
    input  logic [DATA_AW-1:0] tb_wr_addr,
    input  data_t              tb_wr_data
);

    data_t              mem [2**DATA_AW];
    logic               rd_en;
    logic [DATA_AW-1:0] rd_addr;
    data_t              rd_q;
    logic               wr_en;
    logic [DATA_AW-1:0] wr_addr;
    data_t              wr_data;

    // ======================================================================
    // Port muxes, engine first then testbench
    // ======================================================================
    always_comb begin
        rd_en   = eng.rd_en || tb_rd_en;
        rd_addr = eng.rd_en ? eng.rd_addr : tb_rd_addr;
    end

    always_comb begin
        wr_en   = eng.wr_en || tb_wr_en;
        wr_addr = eng.wr_en ? eng.wr_addr : tb_wr_addr;
        wr_data = eng.wr_en ? eng.wr_data : tb_wr_data;
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    assign eng.rd_data = rd_q;
    assign tb_rd_data  = rd_q;

endmodule

/* hdl/dma_shim.sv */
module dma_shim
    import graph_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dma_issue,
    input  dma_instr_t dma_instr,
    input  logic       dma_done_pulse,
    output logic       credit_return,
    output logic       dma_cmd_captured,
    output logic [7:0] dma_sram_addr,
    output logic [7:0] dma_ddr_page,
    output logic [7:0] dma_length,
    output logic       dma_direction
);

    // High while the single credit is out
    logic active;
    logic accept;

    assign accept = dma_issue && !active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active           <= 1'b0;
            dma_cmd_captured <= 1'b0;
        end else begin
            dma_cmd_captured <= accept;
            if (accept) begin
                active <= 1'b1;
            end else if (dma_done_pulse && active) begin
                active <= 1'b0;
            end
        end
    end

    // Fields stay at the outputs until the next command
    always_ff @(posedge clk) begin
        if (accept) begin
            dma_sram_addr <= dma_instr.sram_addr;
            dma_ddr_page  <= dma_instr.ddr_page;
            dma_length    <= dma_instr.length;
            dma_direction <= dma_instr.direction;
        end
    end

    // A done pulse with no command pending is dropped
    assign credit_return = dma_done_pulse && active;

endmodule

/* hdl/ew_engine.sv */
module ew_engine
    import npu_pkg::*;
    import graph_isa_pkg::*;
#(
    parameter int DATA_AW = npu_pkg::DATA_AW
)(
    input  logic       clk,
    input  logic       rst_n,
    ew_cmd_if.eng      cmd,
    sram_port_if.master mem
);

    logic [DATA_AW-1:0] src_q;
    logic [DATA_AW-1:0] dst_q;
    logic [7:0]         len_q;
    ew_func_e           func_q;
    logic               rd_active;
    logic [7:0]         rd_off;
    logic               rd_last;
    logic               s1_valid;
    logic               s1_last;
    logic [7:0]         s1_off;
    logic               s2_valid;
    logic               s2_last;
    logic [7:0]         s2_off;
    data_t              s2_data;
    data_t              result;
    logic               zero_done;

    assign rd_last = (rd_off == len_q - 8'd1);

    // Function applied to the byte returned in stage 1
    // NEG and ABS wrap, so -128 maps to itself
    always_comb begin
        case (func_q)
            FN_RELU: result = (mem.rd_data < 0) ? '0 : mem.rd_data;
            FN_NEG:  result = -mem.rd_data;
            FN_ABS:  result = (mem.rd_data < 0) ? -mem.rd_data : mem.rd_data;
            default: result = mem.rd_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_off    <= '0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            zero_done <= 1'b0;
        end else begin
            zero_done <= cmd.valid && (cmd.len == 8'd0);
            s1_valid  <= rd_active;
            s2_valid  <= s1_valid;
            if (cmd.valid) begin
                rd_active <= (cmd.len != 8'd0);
                rd_off    <= '0;
            end else if (rd_active) begin
                rd_active <= !rd_last;
                rd_off    <= rd_off + 8'd1;
            end
        end
    end

    // Offset travels with each element so the write lands at dst + offset
    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            src_q  <= DATA_AW'(cmd.src);
            dst_q  <= DATA_AW'(cmd.dst);
            len_q  <= cmd.len;
            func_q <= cmd.func;
        end
        s1_off  <= rd_off;
        s1_last <= rd_last;
        s2_off  <= s1_off;
        s2_last <= s1_last;
        s2_data <= result;
    end

    assign mem.rd_en   = rd_active;
    assign mem.rd_addr = src_q + DATA_AW'(rd_off);
    assign mem.wr_en   = s2_valid;
    assign mem.wr_addr = dst_q + DATA_AW'(s2_off);
    assign mem.wr_data = s2_data;
    assign cmd.done    = (s2_valid && s2_last) || zero_done;

endmodule

/* hdl/graph_sequencer.sv */
module graph_sequencer
    import graph_isa_pkg::*;
#(
    parameter int PROG_AW = npu_pkg::PROG_AW
)(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [7:0]         prog_len,
    input  logic               prog_wr_en,
    input  logic [PROG_AW-1:0] prog_wr_addr,
    input  logic [31:0]        prog_wr_data,
    input  logic               credit_return,
    ew_cmd_if.seq              ew,
    output logic               dma_issue,
    output dma_instr_t         dma_instr,
    output logic               graph_done,
    output logic               graph_busy,
    output logic [7:0]         graph_pc
);

    localparam logic [1:0] S_IDLE     = 2'd0;
    localparam logic [1:0] S_FETCH    = 2'd1;
    localparam logic [1:0] S_DISPATCH = 2'd2;
    localparam logic [1:0] S_DRAIN    = 2'd3;

    graph_instr_u       prog_mem [2**PROG_AW];
    graph_instr_u       instr_q;
    logic [1:0]         state;
    logic [PROG_AW-1:0] pc;
    logic [7:0]         issued;
    logic [1:0]         credit;
    logic               ew_idle;
    logic               ew_go;
    logic               dma_go;
    logic               skip_go;
    logic               end_hit;
    logic               advance;
    logic               last_instr;

    // ======================================================================
    // Decode and dispatch conditions
    // ======================================================================
    always_comb begin
        ew_go   = 1'b0;
        dma_go  = 1'b0;
        skip_go = 1'b0;
        end_hit = 1'b0;
        if (state == S_DISPATCH) begin
            case (instr_q.ew.opcode)
                OP_EW:   ew_go   = ew_idle;
                // Stall here until the shim hands the credit back
                OP_DMA:  dma_go  = (credit != 2'd0);
                OP_END:  end_hit = 1'b1;
                default: skip_go = 1'b1;
            endcase
        end
    end

    assign advance    = ew_go || dma_go || skip_go;
    assign last_instr = (issued + 8'd1 == prog_len);
    assign graph_pc   = 8'(pc);

    // ======================================================================
    // Control FSM, credit and engine tracking
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            pc         <= '0;
            issued     <= '0;
            credit     <= 2'd1;
            ew_idle    <= 1'b1;
            ew.valid   <= 1'b0;
            dma_issue  <= 1'b0;
            graph_done <= 1'b0;
            graph_busy <= 1'b0;
        end else begin
            ew.valid   <= ew_go;
            dma_issue  <= dma_go;
            graph_done <= 1'b0;

            // Engine is idle from its done until the next dispatch
            if (ew_go) begin
                ew_idle <= 1'b0;
            end else if (ew.done) begin
                ew_idle <= 1'b1;
            end

            if (dma_go && !credit_return) begin
                credit <= credit - 2'd1;
            end else if (credit_return && !dma_go) begin
                credit <= credit + 2'd1;
            end

            case (state)
                S_IDLE: begin
                    if (start) begin
                        graph_busy <= 1'b1;
                        pc         <= '0;
                        issued     <= '0;
                        state      <= (prog_len == 8'd0) ? S_DRAIN : S_FETCH;
                    end
                end
                S_FETCH: state <= S_DISPATCH;
                S_DISPATCH: begin
                    if (advance) begin
                        pc     <= pc + 1'b1;
                        issued <= issued + 8'd1;
                        state  <= last_instr ? S_DRAIN : S_FETCH;
                    end else if (end_hit) begin
                        state <= S_DRAIN;
                    end
                end
                // Wait for the engine and any DMA in flight
                S_DRAIN: begin
                    if (ew_idle && credit == 2'd1) begin
                        graph_done <= 1'b1;
                        graph_busy <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ======================================================================
    // Program memory and command payload
    // ======================================================================
    always_ff @(posedge clk) begin
        if (prog_wr_en) begin
            prog_mem[prog_wr_addr] <= prog_wr_data;
        end
        if (state == S_FETCH) begin
            instr_q <= prog_mem[pc];
        end
        if (ew_go) begin
            ew.func <= instr_q.ew.func;
            ew.src  <= instr_q.ew.src;
            ew.dst  <= instr_q.ew.dst;
            ew.len  <= instr_q.ew.len;
        end
        if (dma_go) begin
            dma_instr <= instr_q.dma;
        end
    end

endmodule

/* hdl/graph_intf.sv */
// Element-wise command from the sequencer to the engine
interface ew_cmd_if
    import npu_pkg::*;
    import graph_isa_pkg::*;
();

    logic       valid;
    ew_func_e   func;
    addr_t      src;
    addr_t      dst;
    logic [7:0] len;
    logic       done;

    modport seq (output valid, func, src, dst, len, input done);
    modport eng (input valid, func, src, dst, len, output done);

endinterface

// One read and one write port into the data SRAM
interface sram_port_if
    import npu_pkg::*;
#(
    parameter int DATA_AW = npu_pkg::DATA_AW
)();

    logic               rd_en;
    logic [DATA_AW-1:0] rd_addr;
    data_t              rd_data;
    logic               wr_en;
    logic [DATA_AW-1:0] wr_addr;
    data_t              wr_data;

    modport master (output rd_en, rd_addr, wr_en, wr_addr, wr_data, input rd_data);
    modport slave  (input rd_en, rd_addr, wr_en, wr_addr, wr_data, output rd_data);

endinterface

/* hdl/graph_isa_pkg.sv */
package graph_isa_pkg;

    // ======================================================================
    // Opcodes and element-wise functions
    // ======================================================================
    typedef enum logic [3:0] {
        OP_EW  = 4'h1,
        OP_DMA = 4'h2,
        OP_END = 4'hf
    } opcode_e;

    typedef enum logic [3:0] {
        FN_RELU = 4'h0,
        FN_NEG  = 4'h1,
        FN_ABS  = 4'h2
    } ew_func_e;

    // ======================================================================
    // Instruction word views
    // ======================================================================
    // Element-wise view, len of zero touches nothing
    typedef struct packed {
        opcode_e    opcode;
        ew_func_e   func;
        logic [7:0] src;
        logic [7:0] dst;
        logic [7:0] len;
    } ew_instr_t;

    typedef struct packed {
        opcode_e    opcode;
        logic       direction;
        logic [2:0] pad;
        logic [7:0] sram_addr;
        logic [7:0] ddr_page;
        logic [7:0] length;
    } dma_instr_t;

    // Opcode sits in the same top nibble of both views
    typedef union packed {
        ew_instr_t  ew;
        dma_instr_t dma;
    } graph_instr_u;

endpackage

/* hdl/npu_pkg.sv */
package npu_pkg;

    // ======================================================================
    // Data path widths
    // ======================================================================
    localparam int DATA_W  = 8;

    // Data SRAM address width, 256 bytes by default
    localparam int DATA_AW = 8;

    // Program memory address width, 64 words by default
    localparam int PROG_AW = 6;

    // ======================================================================
    // Shared types
    // ======================================================================
    // One signed tensor element
    typedef logic signed [DATA_W-1:0] data_t;

    // Address as carried in instruction fields
    typedef logic [DATA_AW-1:0] addr_t;

endpackage
